// ==== logic/vga_pkg.sv ====
/* vga pipeline shared types
   pixel bus, colour, coordinate, rect controller states and fixed colours */

package vga_pkg;

    // screen coordinate, wide enough for 800x600 totals
    typedef logic [10:0] pos_t;

    // 4 bits per channel, red in the top nibble
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // one pixel slot travelling between stages
    typedef struct packed {
        pos_t hcount;
        pos_t vcount;
        logic hsync;
        logic vsync;
        logic hblnk;
        logic vblnk;
        rgb_t rgb;
    } vga_bus_t;

    // rectangle position controller
    typedef enum logic {
        RECT_IDLE,
        RECT_PENDING
    } rect_state_t;

    // background palette
    localparam rgb_t COLOR_BORDER = 12'hfff;
    localparam rgb_t COLOR_LEFT   = 12'h048;
    localparam rgb_t COLOR_RIGHT  = 12'h480;
    localparam rgb_t COLOR_BLANK  = 12'h000;

endpackage

// ==== logic/vga_timing.sv ====
/* vga timing generator
   beam counters with sync and blanking, registered onto the pixel bus */

`timescale 1ns/1ps

module vga_timing #(
    parameter int H_ACTIVE = 800,
    parameter int H_FP     = 40,
    parameter int H_SYNC   = 128,
    parameter int H_BP     = 88,
    parameter int V_ACTIVE = 600,
    parameter int V_FP     = 1,
    parameter int V_SYNC   = 4,
    parameter int V_BP     = 23
) (
    input  logic              clk,
    input  logic              arst_n,
    output vga_pkg::vga_bus_t tim_out
);
    import vga_pkg::*;

    localparam int H_TOTAL      = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL      = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int H_SYNC_START = H_ACTIVE + H_FP;
    localparam int V_SYNC_START = V_ACTIVE + V_FP;

    pos_t     h_cnt;
    pos_t     v_cnt;
    logic     h_last;
    logic     v_last;
    vga_bus_t tim_nxt;

    // wrap points
    assign h_last = (h_cnt == pos_t'(H_TOTAL - 1));
    assign v_last = (v_cnt == pos_t'(V_TOTAL - 1));

    // beam counters
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            // next line, or back to the top
            v_cnt <= v_last ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // decode sync and blanking from the current count
    always_comb begin
        tim_nxt        = '0;
        tim_nxt.hcount = h_cnt;
        tim_nxt.vcount = v_cnt;
        // active-high sync pulses after the front porch
        tim_nxt.hsync  = (h_cnt >= pos_t'(H_SYNC_START))
                      && (h_cnt < pos_t'(H_SYNC_START + H_SYNC));
        tim_nxt.vsync  = (v_cnt >= pos_t'(V_SYNC_START))
                      && (v_cnt < pos_t'(V_SYNC_START + V_SYNC));
        tim_nxt.hblnk  = (h_cnt >= pos_t'(H_ACTIVE));
        tim_nxt.vblnk  = (v_cnt >= pos_t'(V_ACTIVE));
        // colour is filled in by later stages
        tim_nxt.rgb    = COLOR_BLANK;
    end

    // bus lags the counters by one clock
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tim_out <= '0;
        end else begin
            tim_out <= tim_nxt;
        end
    end

    // counters must never run past the frame size
    a_beam_range: assert property (@(posedge clk) disable iff (!arst_n)
        (h_cnt < pos_t'(H_TOTAL)) && (v_cnt < pos_t'(V_TOTAL)))
        else $error("beam counter out of range h=%0d v=%0d", h_cnt, v_cnt);

endmodule

// ==== logic/rect_ctl.sv ====
/* rectangle position controller
   latches and clamps a requested position, applies it at frame start */

`timescale 1ns/1ps

module rect_ctl #(
    parameter int H_ACTIVE = 800,
    parameter int V_ACTIVE = 600,
    parameter int RECT_W   = 64,
    parameter int RECT_H   = 48
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              pos_load,
    input  vga_pkg::pos_t     pos_x,
    input  vga_pkg::pos_t     pos_y,
    input  vga_pkg::vga_bus_t tim_in,
    output vga_pkg::pos_t     rect_x,
    output vga_pkg::pos_t     rect_y
);
    import vga_pkg::*;

    // furthest top-left corner that keeps the box on screen
    localparam pos_t X_MAX = pos_t'(H_ACTIVE - RECT_W);
    localparam pos_t Y_MAX = pos_t'(V_ACTIVE - RECT_H);

    rect_state_t state;
    rect_state_t state_nxt;
    pos_t        req_x;
    pos_t        req_y;
    logic        frame_start;

    // top-left pixel of a frame on the timing bus
    assign frame_start = (tim_in.hcount == '0) && (tim_in.vcount == '0);

    // requested position is clamped on the way in
    // a later load simply overwrites
    always_ff @(posedge clk) begin
        if (pos_load) begin
            req_x <= (pos_x > X_MAX) ? X_MAX : pos_x;
            req_y <= (pos_y > Y_MAX) ? Y_MAX : pos_y;
        end
    end

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            RECT_IDLE: begin
                if (pos_load) begin
                    state_nxt = RECT_PENDING;
                end
            end
            RECT_PENDING: begin
                // a fresh load at frame start waits for the next frame
                if (!pos_load && frame_start) begin
                    state_nxt = RECT_IDLE;
                end
            end
            default: state_nxt = RECT_IDLE;
        endcase
    end

    // state and applied position
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= RECT_IDLE;
            rect_x <= '0;
            rect_y <= '0;
        end else begin
            state <= state_nxt;
            // frame start publishes the request already held
            if (state == RECT_PENDING && frame_start) begin
                rect_x <= req_x;
                rect_y <= req_y;
            end
        end
    end

    // position reaching the drawing stage is always in range
    a_rect_clamped: assert property (@(posedge clk) disable iff (!arst_n)
        (rect_x <= X_MAX) && (rect_y <= Y_MAX))
        else $error("rect position out of range x=%0d y=%0d", rect_x, rect_y);

endmodule

// ==== logic/draw_bg.sv ====
/* background stage
   white frame border, one colour per half, one clock of latency */

`timescale 1ns/1ps

module draw_bg #(
    parameter int H_ACTIVE = 800,
    parameter int V_ACTIVE = 600
) (
    input  logic              clk,
    input  logic              arst_n,
    input  vga_pkg::vga_bus_t bg_in,
    output vga_pkg::vga_bus_t bg_out
);
    import vga_pkg::*;

    localparam pos_t H_LAST = pos_t'(H_ACTIVE - 1);
    localparam pos_t V_LAST = pos_t'(V_ACTIVE - 1);
    localparam pos_t H_HALF = pos_t'(H_ACTIVE / 2);

    logic is_border;
    rgb_t rgb_nxt;

    // outermost active rows and columns
    assign is_border = (bg_in.hcount == '0) || (bg_in.hcount == H_LAST)
                    || (bg_in.vcount == '0) || (bg_in.vcount == V_LAST);

    // colour pick, highest priority first
    always_comb begin
        if (bg_in.hblnk || bg_in.vblnk) begin
            rgb_nxt = COLOR_BLANK;
        end else if (is_border) begin
            rgb_nxt = COLOR_BORDER;
        end else if (bg_in.hcount < H_HALF) begin
            rgb_nxt = COLOR_LEFT;
        end else begin
            rgb_nxt = COLOR_RIGHT;
        end
    end

    // timing fields ride along unchanged
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bg_out <= '0;
        end else begin
            bg_out     <= bg_in;
            bg_out.rgb <= rgb_nxt;
        end
    end

endmodule

// ==== logic/draw_rect.sv ====
/* rectangle overlay stage
   paints a solid box over the background, one clock of latency */

`timescale 1ns/1ps

module draw_rect #(
    parameter int            RECT_W     = 64,
    parameter int            RECT_H     = 48,
    parameter vga_pkg::rgb_t RECT_COLOR = 12'hf80
) (
    input  logic              clk,
    input  logic              arst_n,
    input  vga_pkg::pos_t     rect_x,
    input  vga_pkg::pos_t     rect_y,
    input  vga_pkg::vga_bus_t rect_in,
    output vga_pkg::vga_bus_t rect_out
);
    import vga_pkg::*;

    pos_t x_last;
    pos_t y_last;
    logic in_x;
    logic in_y;
    logic active;
    rgb_t rgb_nxt;

    // inclusive far edges of the box
    assign x_last = rect_x + pos_t'(RECT_W - 1);
    assign y_last = rect_y + pos_t'(RECT_H - 1);

    assign in_x   = (rect_in.hcount >= rect_x) && (rect_in.hcount <= x_last);
    assign in_y   = (rect_in.vcount >= rect_y) && (rect_in.vcount <= y_last);
    assign active = !rect_in.hblnk && !rect_in.vblnk;

    // never paint into the porches
    always_comb begin
        if (active && in_x && in_y) begin
            rgb_nxt = RECT_COLOR;
        end else begin
            rgb_nxt = rect_in.rgb;
        end
    end

    // output register, sync fields delayed with the colour
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rect_out <= '0;
        end else begin
            rect_out     <= rect_in;
            rect_out.rgb <= rgb_nxt;
        end
    end

    // blanking zeroed upstream must survive to the pins
    a_blank_black: assert property (@(posedge clk) disable iff (!arst_n)
        (rect_out.hblnk || rect_out.vblnk) |-> (rect_out.rgb == COLOR_BLANK))
        else $error("colour %h during blanking", rect_out.rgb);

endmodule

// ==== logic/top_vga.sv ====
/* vga pixel pipeline top
   timing, background and rectangle stages driving the vga pins */

`timescale 1ns/1ps

module top_vga #(
    parameter int            H_ACTIVE   = 800,
    parameter int            H_FP       = 40,
    parameter int            H_SYNC     = 128,
    parameter int            H_BP       = 88,
    parameter int            V_ACTIVE   = 600,
    parameter int            V_FP       = 1,
    parameter int            V_SYNC     = 4,
    parameter int            V_BP       = 23,
    parameter int            RECT_W     = 64,
    parameter int            RECT_H     = 48,
    parameter vga_pkg::rgb_t RECT_COLOR = 12'hf80
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          pos_load,
    input  vga_pkg::pos_t pos_x,
    input  vga_pkg::pos_t pos_y,
    output logic          hs,
    output logic          vs,
    output logic [3:0]    r,
    output logic [3:0]    g,
    output logic [3:0]    b
);
    import vga_pkg::*;

    // bus after each stage
    vga_bus_t tim_bus;
    vga_bus_t bg_bus;
    vga_bus_t out_bus;

    pos_t rect_x;
    pos_t rect_y;

    // pins straight from the last stage register
    assign hs = out_bus.hsync;
    assign vs = out_bus.vsync;
    assign r  = out_bus.rgb.r;
    assign g  = out_bus.rgb.g;
    assign b  = out_bus.rgb.b;

    vga_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FP     (H_FP),
        .H_SYNC   (H_SYNC),
        .H_BP     (H_BP),
        .V_ACTIVE (V_ACTIVE),
        .V_FP     (V_FP),
        .V_SYNC   (V_SYNC),
        .V_BP     (V_BP)
    ) u_vga_timing (
        .clk     (clk),
        .arst_n  (arst_n),
        .tim_out (tim_bus)
    );

    // position updates aligned to the timing bus frame start
    rect_ctl #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE),
        .RECT_W   (RECT_W),
        .RECT_H   (RECT_H)
    ) u_rect_ctl (
        .clk      (clk),
        .arst_n   (arst_n),
        .pos_load (pos_load),
        .pos_x    (pos_x),
        .pos_y    (pos_y),
        .tim_in   (tim_bus),
        .rect_x   (rect_x),
        .rect_y   (rect_y)
    );

    draw_bg #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE)
    ) u_draw_bg (
        .clk    (clk),
        .arst_n (arst_n),
        .bg_in  (tim_bus),
        .bg_out (bg_bus)
    );

    draw_rect #(
        .RECT_W     (RECT_W),
        .RECT_H     (RECT_H),
        .RECT_COLOR (RECT_COLOR)
    ) u_draw_rect (
        .clk      (clk),
        .arst_n   (arst_n),
        .rect_x   (rect_x),
        .rect_y   (rect_y),
        .rect_in  (bg_bus),
        .rect_out (out_bus)
    );

endmodule

// ==== verif/clk_gen.sv ====
/* testbench clock source
   free-running clock with a configurable period */

`timescale 1ns/1ps

module clk_gen #(
    parameter real PERIOD = 8.0
) (
    output logic clk
);

    // half period per toggle
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

endmodule

// ==== verif/top_vga_tb.sv ====
/* vga pipeline testbench
   replays stimulus commands, rebuilds the beam from hs/vs and checks pixels */

`timescale 1ns/1ps

module top_vga_tb;
    import vga_pkg::*;

    // small screen keeps frames short
    localparam int H_ACTIVE   = 64;
    localparam int H_FP       = 4;
    localparam int H_SYNC     = 8;
    localparam int H_BP       = 4;
    localparam int V_ACTIVE   = 48;
    localparam int V_FP       = 2;
    localparam int V_SYNC     = 2;
    localparam int V_BP       = 2;
    localparam int H_TOTAL    = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL    = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int FRAME      = H_TOTAL * V_TOTAL;
    localparam int TIMEOUT    = 2 * FRAME;
    // beam position on the first cycle after each sync pulse
    localparam int H_SYNC_END = H_ACTIVE + H_FP + H_SYNC;
    localparam int V_SYNC_END = V_ACTIVE + V_FP + V_SYNC;

    logic       clk;
    logic       arst_n;
    logic       pos_load;
    pos_t       pos_x;
    pos_t       pos_y;
    logic       hs;
    logic       vs;
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;

    // command words, four per command
    logic [11:0] stim [0:255];
    int          idx;
    logic        chained = 1'b0;

    // rebuilt beam state, updated on the falling edge
    int          bx = 0;
    int          by = 0;
    logic        x_ok = 1'b0;
    logic        beam_ok = 1'b0;
    logic        prev_hs = 1'b0;
    logic        prev_vs = 1'b0;
    logic [11:0] pix = '0;
    int          cyc = 0;
    int          hs_rise = 0;
    int          hs_per = 0;
    int          hs_wid = 0;
    int          vs_rise = 0;
    int          vs_per = 0;

    clk_gen #(.PERIOD(8.0)) u_clk_gen (.clk(clk));

    top_vga #(
        .H_ACTIVE   (H_ACTIVE),
        .H_FP       (H_FP),
        .H_SYNC     (H_SYNC),
        .H_BP       (H_BP),
        .V_ACTIVE   (V_ACTIVE),
        .V_FP       (V_FP),
        .V_SYNC     (V_SYNC),
        .V_BP       (V_BP),
        .RECT_W     (10),
        .RECT_H     (6),
        .RECT_COLOR (12'hf80)
    ) dut0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .pos_load (pos_load),
        .pos_x    (pos_x),
        .pos_y    (pos_y),
        .hs       (hs),
        .vs       (vs),
        .r        (r),
        .g        (g),
        .b        (b)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display("Some tests failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("Some tests failed");
        $fatal(1, "wait limit reached");
    endtask

    // sampling and driving happen after a rising edge
    task automatic wait_pixel(input int x, input int y);
        int n;
        n = 0;
        @(posedge clk);
        while (!(beam_ok && bx == x && by == y)) begin
            if (n == TIMEOUT) begin
                stop_on_timeout($sformatf("beam at %0d,%0d", x, y));
            end
            n++;
            @(posedge clk);
        end
    endtask

    // load at the top of vblank, unless it follows a load that did not wait
    task automatic load_pos(input pos_t x, input pos_t y, input logic wait_after);
        if (!chained) begin
            wait_pixel(0, V_ACTIVE);
        end else begin
            @(posedge clk);
        end
        pos_load <= 1'b1;
        pos_x    <= x;
        pos_y    <= y;
        @(posedge clk);
        pos_load <= 1'b0;
        if (wait_after) begin
            wait_pixel(0, 0);
            chained = 1'b0;
        end else begin
            chained = 1'b1;
        end
    endtask

    // beam tracking from the sync pins
    always @(negedge clk) begin
        if (!arst_n) begin
            x_ok    = 1'b0;
            beam_ok = 1'b0;
            prev_hs = 1'b0;
            prev_vs = 1'b0;
        end else begin
            cyc++;
            if (prev_hs && !hs) begin
                bx     = H_SYNC_END;
                x_ok   = 1'b1;
                hs_wid = cyc - hs_rise;
            end else if (x_ok) begin
                bx = (bx + 1) % H_TOTAL;
            end
            if (!prev_hs && hs) begin
                hs_per  = cyc - hs_rise;
                hs_rise = cyc;
            end
            // vs drops together with the start of a line
            if (prev_vs && !vs) begin
                by      = V_SYNC_END;
                beam_ok = x_ok;
            end else if (beam_ok && bx == 0) begin
                by = (by + 1) % V_TOTAL;
            end
            if (!prev_vs && vs) begin
                vs_per  = cyc - vs_rise;
                vs_rise = cyc;
            end
            prev_hs = hs;
            prev_vs = vs;
            pix     = {r, g, b};
        end
    end

    initial begin
        arst_n   = 1'b0;
        pos_load = 1'b0;
        pos_x    = '0;
        pos_y    = '0;
        $readmemh("verif/vga_stimulus.txt", stim);
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;

        // 1 load x y wait, 2 sample x y rgb
        idx = 0;
        while (idx < 252 && (stim[idx] == 12'd1 || stim[idx] == 12'd2)) begin
            if (stim[idx] == 12'd1) begin
                load_pos(stim[idx+1][10:0], stim[idx+2][10:0], stim[idx+3][0]);
            end else begin
                wait_pixel(stim[idx+1], stim[idx+2]);
                check_value($sformatf("{r,g,b} at %0d,%0d", stim[idx+1], stim[idx+2]),
                            pix, stim[idx+3]);
            end
            idx += 4;
        end
        check_value("stimulus end marker", stim[idx], 0);

        // sync periods, measured over the whole run
        check_value("hs period", hs_per, H_TOTAL);
        check_value("hs width", hs_wid, H_SYNC);
        check_value("vs period", vs_per, FRAME);

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== build.f ====
logic/vga_pkg.sv
logic/vga_timing.sv
logic/rect_ctl.sv
logic/draw_bg.sv
logic/draw_rect.sv
logic/top_vga.sv
verif/clk_gen.sv
verif/top_vga_tb.sv

// ==== verif/vga_stimulus.txt ====
// hex columns: cmd a b c
// cmd 1 load x=a y=b, c=1 waits for the next frame; cmd 2 sample x=a y=b rgb=c; 0 ends
2 003 003 f80
2 00a 003 048
1 01b 015 001
2 000 00a fff
2 03f 00a fff
2 014 000 fff
2 005 005 048
2 020 01e 480
2 01b 015 f80
2 024 01a f80
2 01a 017 048
2 025 017 480
2 01e 014 048
2 021 01b 480
2 040 00a 000
2 046 00a 000
2 04e 00a 000
2 00a 030 000
1 03c 02d 001
2 036 02a f80
2 03f 02f f80
2 035 02c 480
2 03a 029 480
1 005 005 000
1 028 01e 001
2 00a 008 048
2 028 01e f80
2 031 023 f80
2 027 01e 480
0 000 000 000
